//--- flist.f
hw/mem_pkg.sv
hw/axi_lite_if.sv
hw/axi_read_arbiter.sv
hw/axi_lite_sram.sv
hw/mem_subsystem.sv
test/mem_subsystem_assertions.sv
test/tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log has the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_mem_subsystem \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "^Test OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- test/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int MEM_WORDS = 256;
    localparam int MAX_CYCLES = 3000;  // ~150 transactions of up to 16 cycles plus reset

    logic           clk = 1'b0;
    logic           rst_n;
    logic           if_ar_valid_i;
    mem_pkg::addr_t if_ar_addr_i;
    logic           if_ar_ready_o;
    logic           if_r_valid_o;
    logic           if_r_ready_i;
    mem_pkg::data_t if_r_data_o;
    mem_pkg::resp_t if_r_resp_o;
    logic           ls_ar_valid_i;
    mem_pkg::addr_t ls_ar_addr_i;
    logic           ls_ar_ready_o;
    logic           ls_r_valid_o;
    logic           ls_r_ready_i;
    mem_pkg::data_t ls_r_data_o;
    mem_pkg::resp_t ls_r_resp_o;
    logic           ls_aw_valid_i;
    mem_pkg::addr_t ls_aw_addr_i;
    logic           ls_aw_ready_o;
    logic           ls_w_valid_i;
    mem_pkg::data_t ls_w_data_i;
    mem_pkg::strb_t ls_w_strb_i;
    logic           ls_w_ready_o;
    logic           ls_b_valid_o;
    logic           ls_b_ready_i;
    mem_pkg::resp_t ls_b_resp_o;
    int unsigned    cycles = 0;

    mem_subsystem #(.MEM_WORDS(MEM_WORDS)) DUT (.*);

    bind mem_subsystem mem_subsystem_assertions #(.MEM_WORDS(MEM_WORDS)) u_checks (.*);

    always #10 clk = !clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles", cycles);
            $display("Test FAILED");
            $fatal(1, "simulation did not finish in time");
        end
    end

    // **************************************************
    // bus tasks, all start 1 ns after a rising edge
    // **************************************************
    task automatic write_word(input mem_pkg::addr_t a, input mem_pkg::data_t d,
                              input mem_pkg::strb_t s);
        ls_aw_valid_i = 1'b1;
        ls_aw_addr_i  = a;
        ls_w_valid_i  = 1'b1;
        ls_w_data_i   = d;
        ls_w_strb_i   = s;
        @(negedge clk);
        while (!ls_aw_ready_o) @(negedge clk);
        @(posedge clk);
        #1;
        ls_aw_valid_i = 1'b0;
        ls_w_valid_i  = 1'b0;
        forever begin
            ls_b_ready_i = 1'($urandom % 2);  // random back-pressure
            @(negedge clk);
            if (ls_b_valid_o && ls_b_ready_i) break;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        ls_b_ready_i = 1'b0;
    endtask

    task automatic ls_read(input mem_pkg::addr_t a);
        ls_ar_valid_i = 1'b1;
        ls_ar_addr_i  = a;
        @(negedge clk);
        while (!ls_ar_ready_o) @(negedge clk);
        @(posedge clk);
        #1;
        ls_ar_valid_i = 1'b0;
        forever begin
            ls_r_ready_i = 1'($urandom % 2);
            @(negedge clk);
            if (ls_r_valid_o && ls_r_ready_i) break;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        ls_r_ready_i = 1'b0;
    endtask

    task automatic fetch_read(input mem_pkg::addr_t a);
        if_ar_valid_i = 1'b1;
        if_ar_addr_i  = a;
        @(negedge clk);
        while (!if_ar_ready_o) @(negedge clk);
        @(posedge clk);
        #1;
        if_ar_valid_i = 1'b0;
        forever begin
            if_r_ready_i = 1'($urandom % 2);
            @(negedge clk);
            if (if_r_valid_o && if_r_ready_i) break;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        if_r_ready_i = 1'b0;
    endtask

    task automatic idle_gap();
        repeat ($urandom % 3) begin
            @(posedge clk);
            #1;
        end
    endtask

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        void'($urandom(32'h2d49));
        {if_r_ready_i, ls_r_ready_i, ls_b_ready_i} = '0;
        // requests held through reset, nothing may accept them
        {if_ar_valid_i, ls_ar_valid_i, ls_aw_valid_i, ls_w_valid_i} = '1;
        if_ar_addr_i = '0;
        ls_ar_addr_i = '0;
        ls_aw_addr_i = '0;
        ls_w_data_i  = '0;
        ls_w_strb_i  = '0;
        rst_n = 1'b1;  // reset is active high
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b0;
        {if_ar_valid_i, ls_ar_valid_i, ls_aw_valid_i, ls_w_valid_i} = '0;
        repeat (3) @(posedge clk);
        #1;

        // full write then byte merges
        write_word(64'h28, 64'h1122_3344_5566_7788, 8'hff);
        write_word(64'h28, 64'haaaa_aaaa_aaaa_aaaa, 8'h0f);
        write_word(64'h28, 64'hbbbb_bbbb_bbbb_bbbb, 8'h30);
        ls_read(64'h28);
        fetch_read(64'h28);

        for (int i = 0; i < 16; i++) begin
            write_word(mem_pkg::addr_t'(i * 8), {$urandom, $urandom}, 8'hff);
            idle_gap();
        end
        for (int i = 0; i < 16; i++) fetch_read(mem_pkg::addr_t'(i * 8));

        // same-cycle requests, load/store first
        for (int i = 0; i < 10; i++) begin
            fork
                ls_read(mem_pkg::addr_t'(($urandom % 16) * 8));
                fetch_read(mem_pkg::addr_t'(($urandom % 16) * 8));
            join
            idle_gap();
        end

        // mixed traffic with random strobes
        for (int i = 0; i < 40; i++) begin
            case ($urandom % 3)
                0: write_word(mem_pkg::addr_t'(($urandom % 16) * 8), {$urandom, $urandom},
                              8'($urandom));
                1: ls_read(mem_pkg::addr_t'(($urandom % 16) * 8));
                default: fetch_read(mem_pkg::addr_t'(($urandom % 16) * 8));
            endcase
            idle_gap();
        end

        // past the end of the sram
        write_word(64'(MEM_WORDS * 8), 64'hdead_beef_dead_beef, 8'hff);
        write_word(64'(300 * 8), 64'h0123_4567_89ab_cdef, 8'hff);
        ls_read(64'(MEM_WORDS * 8));
        fetch_read(64'(300 * 8));
        ls_read(64'hffff_0000_0000_0000);
        for (int i = 0; i < 4; i++) ls_read(mem_pkg::addr_t'(i * 8));

        repeat (4) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

//--- test/mem_subsystem_assertions.sv
`timescale 1ns/1ps

module mem_subsystem_assertions #(
    parameter int MEM_WORDS = 256
) (
    input logic           clk,
    input logic           rst_n,
    input logic           if_ar_valid_i,
    input mem_pkg::addr_t if_ar_addr_i,
    input logic           if_ar_ready_o,
    input logic           if_r_valid_o,
    input logic           if_r_ready_i,
    input mem_pkg::data_t if_r_data_o,
    input mem_pkg::resp_t if_r_resp_o,
    input logic           ls_ar_valid_i,
    input mem_pkg::addr_t ls_ar_addr_i,
    input logic           ls_ar_ready_o,
    input logic           ls_r_valid_o,
    input logic           ls_r_ready_i,
    input mem_pkg::data_t ls_r_data_o,
    input mem_pkg::resp_t ls_r_resp_o,
    input logic           ls_aw_valid_i,
    input mem_pkg::addr_t ls_aw_addr_i,
    input logic           ls_aw_ready_o,
    input logic           ls_w_valid_i,
    input mem_pkg::data_t ls_w_data_i,
    input mem_pkg::strb_t ls_w_strb_i,
    input logic           ls_w_ready_o,
    input logic           ls_b_valid_o,
    input logic           ls_b_ready_i,
    input mem_pkg::resp_t ls_b_resp_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    mem_pkg::data_t shadow [MEM_WORDS];
    logic           known [MEM_WORDS];   // word written since reset
    mem_pkg::data_t ls_exp_data;
    mem_pkg::data_t if_exp_data;
    mem_pkg::resp_t ls_exp_resp;
    mem_pkg::resp_t if_exp_resp;
    mem_pkg::resp_t b_exp_resp;
    logic           ls_exp_known;
    logic           if_exp_known;
    logic           ls_pend;             // load/store read outstanding
    logic           if_pend;             // fetch read outstanding

    function automatic logic in_range(mem_pkg::addr_t a);
        return (a >> mem_pkg::WORD_SHIFT) < mem_pkg::addr_t'(MEM_WORDS);
    endfunction

    // word select inside the shadow, valid only for in-range addresses
    function automatic logic [IDX_W-1:0] word_idx(mem_pkg::addr_t a);
        return a[mem_pkg::WORD_SHIFT +: IDX_W];
    endfunction

    // **************************************************
    // shadow memory and expected answers
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) known[i] <= 1'b0;
            ls_pend <= 1'b0;
            if_pend <= 1'b0;
        end else begin
            if (ls_aw_valid_i && ls_aw_ready_o) begin
                b_exp_resp <= in_range(ls_aw_addr_i) ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
                if (in_range(ls_aw_addr_i)) begin
                    for (int b = 0; b < mem_pkg::STRB_W; b++) begin
                        if (ls_w_strb_i[b]) begin
                            shadow[word_idx(ls_aw_addr_i)][8*b +: 8] <= ls_w_data_i[8*b +: 8];
                        end
                    end
                    if (ls_w_strb_i == '1) known[word_idx(ls_aw_addr_i)] <= 1'b1;
                end
            end
            if (ls_ar_valid_i && ls_ar_ready_o) begin
                ls_pend      <= 1'b1;
                ls_exp_known <= !in_range(ls_ar_addr_i) || known[word_idx(ls_ar_addr_i)];
                ls_exp_data  <= in_range(ls_ar_addr_i) ? shadow[word_idx(ls_ar_addr_i)] : '0;
                ls_exp_resp  <= in_range(ls_ar_addr_i) ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
            end else if (ls_r_valid_o && ls_r_ready_i) begin
                ls_pend <= 1'b0;
            end
            if (if_ar_valid_i && if_ar_ready_o) begin
                if_pend      <= 1'b1;
                if_exp_known <= !in_range(if_ar_addr_i) || known[word_idx(if_ar_addr_i)];
                if_exp_data  <= in_range(if_ar_addr_i) ? shadow[word_idx(if_ar_addr_i)] : '0;
                if_exp_resp  <= in_range(if_ar_addr_i) ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
            end else if (if_r_valid_o && if_r_ready_i) begin
                if_pend <= 1'b0;
            end
        end
    end

    // **************************************************
    // checks
    // **************************************************
    a_reset_quiet: assert property (@(posedge clk) $past(rst_n) |->
        !if_ar_ready_o && !ls_ar_ready_o && !ls_aw_ready_o && !ls_w_ready_o &&
        !ls_r_valid_o && !if_r_valid_o && !ls_b_valid_o)
        else $error("reset_quiet: a ready or response valid was high during reset");

    a_ls_data: assert property (@(posedge clk) disable iff (rst_n)
        ls_r_valid_o && ls_r_ready_i && ls_exp_known |-> ls_r_data_o == ls_exp_data)
        else $error("mismatch ls_data expected %h actual %h", ls_exp_data, ls_r_data_o);

    a_ls_resp: assert property (@(posedge clk) disable iff (rst_n)
        ls_r_valid_o && ls_r_ready_i |-> ls_r_resp_o == ls_exp_resp)
        else $error("mismatch ls_resp expected %0d actual %0d", ls_exp_resp, ls_r_resp_o);

    a_if_data: assert property (@(posedge clk) disable iff (rst_n)
        if_r_valid_o && if_r_ready_i && if_exp_known |-> if_r_data_o == if_exp_data)
        else $error("mismatch if_data expected %h actual %h", if_exp_data, if_r_data_o);

    a_if_resp: assert property (@(posedge clk) disable iff (rst_n)
        if_r_valid_o && if_r_ready_i |-> if_r_resp_o == if_exp_resp)
        else $error("mismatch if_resp expected %0d actual %0d", if_exp_resp, if_r_resp_o);

    // a read answer only goes to the side that asked for it
    a_ls_r_owner: assert property (@(posedge clk) disable iff (rst_n)
        ls_r_valid_o |-> ls_pend)
        else $error("ls_r_owner: load/store read answer without an outstanding request");

    a_if_r_owner: assert property (@(posedge clk) disable iff (rst_n)
        if_r_valid_o |-> if_pend)
        else $error("if_r_owner: fetch read answer without an outstanding request");

    a_aw_w_together: assert property (@(posedge clk) disable iff (rst_n)
        ls_aw_ready_o || ls_w_ready_o |->
        ls_aw_ready_o && ls_w_ready_o && ls_aw_valid_i && ls_w_valid_i)
        else $error("aw_w_together: aw and w were not accepted together");

    a_b_timing: assert property (@(posedge clk) disable iff (rst_n)
        ls_aw_valid_i && ls_aw_ready_o |=> ls_b_valid_o && ls_b_resp_o == b_exp_resp)
        else $error("mismatch b_resp expected %0d actual %0d", b_exp_resp, ls_b_resp_o);

    a_fetch_stall: assert property (@(posedge clk) disable iff (rst_n)
        ls_ar_valid_i || ls_pend |-> !if_ar_ready_o)
        else $error("fetch_stall: fetch was granted while load/store used the read channel");

    a_ls_r_hold: assert property (@(posedge clk) disable iff (rst_n)
        ls_r_valid_o && !ls_r_ready_i |=>
        ls_r_valid_o && $stable(ls_r_data_o) && $stable(ls_r_resp_o))
        else $error("ls_r_hold: load/store read answer changed under back-pressure");

    a_if_r_hold: assert property (@(posedge clk) disable iff (rst_n)
        if_r_valid_o && !if_r_ready_i |=>
        if_r_valid_o && $stable(if_r_data_o) && $stable(if_r_resp_o))
        else $error("if_r_hold: fetch read answer changed under back-pressure");

    a_b_hold: assert property (@(posedge clk) disable iff (rst_n)
        ls_b_valid_o && !ls_b_ready_i |=> ls_b_valid_o && $stable(ls_b_resp_o))
        else $error("b_hold: write response changed under back-pressure");

endmodule

//--- hw/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rst_n,

    // instruction fetch, read only
    input  logic           if_ar_valid_i,
    input  mem_pkg::addr_t if_ar_addr_i,
    output logic           if_ar_ready_o,
    output logic           if_r_valid_o,
    input  logic           if_r_ready_i,
    output mem_pkg::data_t if_r_data_o,
    output mem_pkg::resp_t if_r_resp_o,

    // load/store
    input  logic           ls_ar_valid_i,
    input  mem_pkg::addr_t ls_ar_addr_i,
    output logic           ls_ar_ready_o,
    output logic           ls_r_valid_o,
    input  logic           ls_r_ready_i,
    output mem_pkg::data_t ls_r_data_o,
    output mem_pkg::resp_t ls_r_resp_o,
    input  logic           ls_aw_valid_i,
    input  mem_pkg::addr_t ls_aw_addr_i,
    output logic           ls_aw_ready_o,
    input  logic           ls_w_valid_i,
    input  mem_pkg::data_t ls_w_data_i,
    input  mem_pkg::strb_t ls_w_strb_i,
    output logic           ls_w_ready_o,
    output logic           ls_b_valid_o,
    input  logic           ls_b_ready_i,
    output mem_pkg::resp_t ls_b_resp_o
);

    axi_lite_if fetch_bus ();  // read channels only
    axi_lite_if lsu_bus ();
    axi_lite_if sram_bus ();

    // **************************************************
    // port mapping
    // **************************************************
    assign fetch_bus.ar_valid = if_ar_valid_i;
    assign fetch_bus.ar_addr  = if_ar_addr_i;
    assign fetch_bus.r_ready  = if_r_ready_i;
    assign if_ar_ready_o      = fetch_bus.ar_ready;
    assign if_r_valid_o       = fetch_bus.r_valid;
    assign if_r_data_o        = fetch_bus.r_data;
    assign if_r_resp_o        = fetch_bus.r_resp;

    assign lsu_bus.ar_valid = ls_ar_valid_i;
    assign lsu_bus.ar_addr  = ls_ar_addr_i;
    assign lsu_bus.r_ready  = ls_r_ready_i;
    assign lsu_bus.aw_valid = ls_aw_valid_i;
    assign lsu_bus.aw_addr  = ls_aw_addr_i;
    assign lsu_bus.w_valid  = ls_w_valid_i;
    assign lsu_bus.w_data   = ls_w_data_i;
    assign lsu_bus.w_strb   = ls_w_strb_i;
    assign lsu_bus.b_ready  = ls_b_ready_i;
    assign ls_ar_ready_o    = lsu_bus.ar_ready;
    assign ls_r_valid_o     = lsu_bus.r_valid;
    assign ls_r_data_o      = lsu_bus.r_data;
    assign ls_r_resp_o      = lsu_bus.r_resp;
    assign ls_aw_ready_o    = lsu_bus.aw_ready;
    assign ls_w_ready_o     = lsu_bus.w_ready;
    assign ls_b_valid_o     = lsu_bus.b_valid;
    assign ls_b_resp_o      = lsu_bus.b_resp;

    axi_read_arbiter u_arbiter (
        .clk   (clk      ),
        .rst_n (rst_n    ),
        .fetch (fetch_bus),
        .lsu   (lsu_bus  ),
        .sram  (sram_bus )
    );

    axi_lite_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk   (clk     ),
        .rst_n (rst_n   ),
        .bus   (sram_bus)
    );

endmodule

//--- hw/axi_lite_sram.sv
`timescale 1ns/1ps

module axi_lite_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst_n,
    axi_lite_if.slave bus
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    mem_pkg::data_t mem [MEM_WORDS];

    logic             run_q;      // set on the first edge out of reset
    mem_pkg::addr_t   ar_word;
    mem_pkg::addr_t   aw_word;
    logic             ar_in_range;
    logic             aw_in_range;
    logic [IDX_W-1:0] ar_idx;
    logic [IDX_W-1:0] aw_idx;
    logic             ar_fire;
    logic             wr_go;

    // word index from byte address
    assign ar_word     = bus.ar_addr >> mem_pkg::WORD_SHIFT;
    assign aw_word     = bus.aw_addr >> mem_pkg::WORD_SHIFT;
    assign ar_in_range = ar_word < mem_pkg::addr_t'(MEM_WORDS);
    assign aw_in_range = aw_word < mem_pkg::addr_t'(MEM_WORDS);
    assign ar_idx      = ar_word[IDX_W-1:0];
    assign aw_idx      = aw_word[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // **************************************************
    // read channel
    // **************************************************
    assign bus.ar_ready = run_q && !bus.r_valid;  // one answer in flight
    assign ar_fire      = bus.ar_valid && bus.ar_ready;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            bus.r_valid <= 1'b0;
        end else if (ar_fire) begin
            bus.r_valid <= 1'b1;
        end else if (bus.r_ready) begin
            bus.r_valid <= 1'b0;
        end
    end

    // payload held while r waits on r_ready
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            bus.r_data <= ar_in_range ? mem[ar_idx] : '0;
            bus.r_resp <= ar_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
        end
    end

    // **************************************************
    // write channels
    // **************************************************
    // aw and w are taken together, never one without the other
    assign wr_go        = run_q && bus.aw_valid && bus.w_valid && !bus.b_valid;
    assign bus.aw_ready = wr_go;
    assign bus.w_ready  = wr_go;

    always_ff @(posedge clk) begin
        if (wr_go && aw_in_range) begin
            for (int i = 0; i < mem_pkg::STRB_W; i++) begin
                if (bus.w_strb[i]) begin
                    mem[aw_idx][8*i +: 8] <= bus.w_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            bus.b_valid <= 1'b0;
        end else if (wr_go) begin
            bus.b_valid <= 1'b1;  // one cycle after the aw/w transfer
        end else if (bus.b_ready) begin
            bus.b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            bus.b_resp <= aw_in_range ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
        end
    end

endmodule

//--- hw/axi_read_arbiter.sv
`timescale 1ns/1ps

module axi_read_arbiter (
    input  logic        clk,
    input  logic        rst_n,
    axi_lite_if.rd_slave fetch,
    axi_lite_if.slave    lsu,
    axi_lite_if.master   sram
);

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_FETCH,
        OWN_LSU
    } owner_t;

    owner_t owner_q;  // who holds the read channel
    logic   sel_lsu;
    logic   sel_fetch;
    logic   ar_fire;
    logic   r_fire;

    // **************************************************
    // read address, load/store before fetch
    // **************************************************
    // fetch is stalled whenever load/store asks for the channel;
    // while a read is outstanding neither side gets ar_ready
    assign sel_lsu   = (owner_q == OWN_IDLE) && lsu.ar_valid;
    assign sel_fetch = (owner_q == OWN_IDLE) && !lsu.ar_valid && fetch.ar_valid;

    assign sram.ar_valid = sel_lsu || sel_fetch;
    assign sram.ar_addr  = lsu.ar_valid ? lsu.ar_addr : fetch.ar_addr;

    assign lsu.ar_ready   = sel_lsu && sram.ar_ready;
    assign fetch.ar_ready = sel_fetch && sram.ar_ready;

    assign ar_fire = sram.ar_valid && sram.ar_ready;
    assign r_fire  = sram.r_valid && sram.r_ready;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            owner_q <= OWN_IDLE;
        end else if (ar_fire) begin
            owner_q <= sel_lsu ? OWN_LSU : OWN_FETCH;  // remember who asked
        end else if (r_fire) begin
            owner_q <= OWN_IDLE;                       // channel free again
        end
    end

    // **************************************************
    // read data back to the owner only
    // **************************************************
    assign lsu.r_valid   = (owner_q == OWN_LSU) && sram.r_valid;
    assign fetch.r_valid = (owner_q == OWN_FETCH) && sram.r_valid;

    // payload goes to both, valid picks the receiver
    assign lsu.r_data   = sram.r_data;
    assign lsu.r_resp   = sram.r_resp;
    assign fetch.r_data = sram.r_data;
    assign fetch.r_resp = sram.r_resp;

    always_comb begin
        case (owner_q)
            OWN_LSU:   sram.r_ready = lsu.r_ready;
            OWN_FETCH: sram.r_ready = fetch.r_ready;
            default:   sram.r_ready = 1'b0;
        endcase
    end

    // **************************************************
    // write path, load/store only
    // **************************************************
    // fetch never writes so aw/w/b go straight through
    assign sram.aw_valid = lsu.aw_valid;
    assign sram.aw_addr  = lsu.aw_addr;
    assign lsu.aw_ready  = sram.aw_ready;

    assign sram.w_valid = lsu.w_valid;
    assign sram.w_data  = lsu.w_data;
    assign sram.w_strb  = lsu.w_strb;
    assign lsu.w_ready  = sram.w_ready;

    assign lsu.b_valid   = sram.b_valid;
    assign lsu.b_resp    = sram.b_resp;
    assign sram.b_ready  = lsu.b_ready;

endmodule

//--- hw/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if;

    // read address / read data
    logic            ar_valid;
    logic            ar_ready;
    mem_pkg::addr_t  ar_addr;
    logic            r_valid;
    logic            r_ready;
    mem_pkg::data_t  r_data;
    mem_pkg::resp_t  r_resp;

    // write address / write data / write response
    logic            aw_valid;
    logic            aw_ready;
    mem_pkg::addr_t  aw_addr;
    logic            w_valid;
    logic            w_ready;
    mem_pkg::data_t  w_data;
    mem_pkg::strb_t  w_strb;
    logic            b_valid;
    logic            b_ready;
    mem_pkg::resp_t  b_resp;

    // **************************************************
    // full bus, all five channels
    // **************************************************
    modport master (
        output ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        input  ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
    );

    modport slave (
        input  ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
        output ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
    );

    // read side only, for the instruction fetch port
    modport rd_master (
        output ar_valid, ar_addr, r_ready,
        input  ar_ready, r_valid, r_data, r_resp
    );

    modport rd_slave (
        input  ar_valid, ar_addr, r_ready,
        output ar_ready, r_valid, r_data, r_resp
    );

endinterface

//--- hw/mem_pkg.sv
package mem_pkg;

    // **************************************************
    // bus widths
    // **************************************************
    localparam int ADDR_W     = 64;          // byte address
    localparam int DATA_W     = 64;          // one memory word
    localparam int STRB_W     = DATA_W / 8;  // one bit per byte lane
    localparam int WORD_SHIFT = 3;           // byte offset bits inside a word

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // response codes on r and b
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2   // address past the end of the sram
    } resp_t;

endpackage
